//--- spmd_harness.f
+incdir+src
src/spmd_pkg.sv
src/tag_programmer.sv
src/spmd_tile.sv
src/spmd_loader.sv
src/spmd_top.sv
verif/spmd_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the spmd harness with Verilator and runs it; exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module spmd_tb \
  --Mdir obj_dir \
  -f spmd_harness.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vspmd_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
fi
exit "$status"

//--- verif/spmd_tb.sv
// random-stimulus testbench for spmd_top with a cycle model; built from the project file list
`timescale 1ns/1ns
`include "spmd_config.svh"

module spmd_tb;

  import spmd_pkg::*;

  localparam int PERIOD_NS    = 100;
  localparam int RESET_CYCLES = 4;
  localparam int READY_LAT    = `SPMD_NUM_TILES + 1 + `SPMD_RESET_DEPTH;
  localparam int PRE_READY    = READY_LAT - 1;  // ticks whose inputs are sampled before ready
  localparam int LOAD_ALL     = `SPMD_NUM_TILES * `SPMD_DMEM_WORDS;
  localparam int RAND_CYCLES  = 240;
  localparam int DRAIN        = `SPMD_DMEM_WORDS + `SPMD_NUM_TILES + 8;
  localparam int RUN_CYCLES   =
    RESET_CYCLES + PRE_READY + LOAD_ALL + RAND_CYCLES + 2 + 4 * DRAIN;

  logic clk;
  logic rst_n;
  key_t tag_seed;
  logic load_v;
  tile_id_t load_tile;
  addr_t load_addr;
  data_t load_data;
  logic start_v;
  tile_mask_t start_mask;
  logic ready;
  logic drop;
  logic stat_v;
  tile_id_t stat_tile;
  data_t stat_result;
  cycle_t stat_cycle;

  logic [31:0] rng_state;
  int edge_n;
  int rel_edge;  // edge that first samples rst_n high minus one
  logic rst_drive;
  string test_name;

  // reference model
  data_t mem_m [`SPMD_NUM_TILES][`SPMD_DMEM_WORDS];
  key_t key_m [`SPMD_NUM_TILES];
  data_t res_m [`SPMD_NUM_TILES];
  data_t slot_m [`SPMD_NUM_TILES];
  int start_m [`SPMD_NUM_TILES];  // sampling edge of last accepted start
  tile_mask_t pend_m;
  int starts_m;
  int records_seen;
  cycle_t last_cycle;

  // what the next edge should produce
  logic exp_drop;
  logic exp_rec_v;
  tile_id_t exp_rec_tile;
  data_t exp_rec_res;
  cycle_t exp_rec_cycle;

  spmd_top u_spmd_top (
    .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.tag_seed_i(tag_seed)
    ,.load_v_i(load_v)
    ,.load_tile_i(load_tile)
    ,.load_addr_i(load_addr)
    ,.load_data_i(load_data)
    ,.start_v_i(start_v)
    ,.start_mask_i(start_mask)
    ,.ready_o(ready)
    ,.drop_o(drop)
    ,.print_stat_v_o(stat_v)
    ,.stat_tile_o(stat_tile)
    ,.stat_result_o(stat_result)
    ,.stat_cycle_o(stat_cycle)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    #((RUN_CYCLES + DRAIN) * PERIOD_NS);
    abort_run("watchdog expired before the test sequence completed");
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // rotate left by one byte per tile index
  function automatic key_t rotl_bytes(key_t v, int k);
    logic [63:0] both;
    int sh;
    both = {v, v};
    sh = (8 * k) % 32;
    return both[63 - sh -: 32];
  endfunction

  function automatic logic is_ready(int e);  // cores out of reset after edge e
    return rel_edge >= 0 && e >= rel_edge + READY_LAT;
  endfunction

  function automatic logic tile_busy(int k, int s);
    return s > start_m[k] && s <= start_m[k] + `SPMD_DMEM_WORDS + 2;
  endfunction

  function automatic data_t kernel_result(int k);
    data_t sum;
    sum = '0;
    for (int i = 0; i < `SPMD_DMEM_WORDS; i++) sum = sum + mem_m[k][i];
    return sum ^ key_m[k];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (exp !== act) begin
      abort_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_tile(input string what, input tile_id_t exp, input tile_id_t act);
    if (exp !== act) begin
      abort_run($sformatf("CHECK FAILED %s %s: expected %0d, actual %0d",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_cycle(input string what, input cycle_t exp, input cycle_t act);
    if (exp !== act) begin
      abort_run($sformatf("CHECK FAILED %s %s: expected %0d, actual %0d",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      abort_run($sformatf("CHECK FAILED %s %s: expected %b, actual %b",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_edge();
    check_flag("ready", is_ready(edge_n), ready);
    check_flag("drop", exp_drop, drop);
    check_flag("record valid", exp_rec_v, stat_v);
    if (exp_rec_v) begin
      check_tile("record tile", exp_rec_tile, stat_tile);
      check_data("record result", exp_rec_res, stat_result);
      check_cycle("record cycle", exp_rec_cycle, stat_cycle);
      check_flag("record cycle increases", 1'b1, stat_cycle > last_cycle);
      last_cycle = stat_cycle;
      records_seen++;
    end
  endtask

  // model the inputs that the DUT samples at edge s
  task automatic predict(input logic lv, input tile_id_t lt, input addr_t la, input data_t ld,
                         input logic sv, input tile_mask_t sm, input int s);
    logic rdy;
    tile_mask_t busy_now;
    tile_mask_t avail;
    rdy = is_ready(s - 1);
    busy_now = '0;
    avail = pend_m;
    for (int k = 0; k < `SPMD_NUM_TILES; k++) begin
      busy_now[k] = tile_busy(k, s);
      if (start_m[k] + `SPMD_DMEM_WORDS + 2 == s - 1) begin  // done pulse just before s
        avail[k] = 1'b1;
        slot_m[k] = res_m[k];
      end
    end
    exp_rec_v = |avail;
    exp_rec_tile = '0;
    for (int k = `SPMD_NUM_TILES - 1; k >= 0; k--) begin
      if (avail[k]) exp_rec_tile = tile_id_t'(k);
    end
    if (exp_rec_v) begin
      exp_rec_res   = slot_m[exp_rec_tile];
      exp_rec_cycle = cycle_t'(s - rel_edge - READY_LAT);
      avail[exp_rec_tile] = 1'b0;
    end
    pend_m = avail;
    exp_drop = 1'b0;
    if (lv) begin
      if (!rdy || busy_now[lt]) exp_drop = 1'b1;
      else mem_m[lt][la] = ld;
    end
    if (sv) begin
      if (!rdy || |(sm & busy_now)) exp_drop = 1'b1;
      for (int k = 0; k < `SPMD_NUM_TILES; k++) begin
        if (rdy && sm[k] && !busy_now[k]) begin  // idle targets still start
          start_m[k] = s;
          res_m[k] = kernel_result(k);
          starts_m++;
        end
      end
    end
  endtask

  task automatic tick(input logic lv, input tile_id_t lt, input addr_t la, input data_t ld,
                      input logic sv, input tile_mask_t sm);
    @(posedge clk);
    edge_n++;
    rst_n      <= rst_drive;
    load_v     <= lv;
    load_tile  <= lt;
    load_addr  <= la;
    load_data  <= ld;
    start_v    <= sv;
    start_mask <= sm;
    if (rst_drive && rel_edge < 0) rel_edge = edge_n;
    @(negedge clk);
    if (rel_edge >= 0) check_edge();
    predict(lv, lt, la, ld, sv, sm, edge_n + 1);
  endtask

  task automatic idle_tick();
    tick(1'b0, '0, '0, '0, 1'b0, '0);
  endtask

  initial begin
    logic [31:0] r;
    data_t d;
    key_t seed;
    int t_lone;
    int waited;
    rng_state = 32'h9ff2;
    edge_n = 0;
    rel_edge = -1;
    rst_drive = 1'b0;
    pend_m = '0;
    starts_m = 0;
    records_seen = 0;
    last_cycle = '0;
    exp_drop = 1'b0;
    exp_rec_v = 1'b0;
    seed = next_rand();
    for (int k = 0; k < `SPMD_NUM_TILES; k++) begin
      key_m[k] = rotl_bytes(seed, k);
      start_m[k] = -1000;
      for (int i = 0; i < `SPMD_DMEM_WORDS; i++) mem_m[k][i] = '0;
    end
    tag_seed   <= seed;  // held for the whole run
    rst_n      <= 1'b0;
    load_v     <= 1'b0;
    load_tile  <= '0;
    load_addr  <= '0;
    load_data  <= '0;
    start_v    <= 1'b0;
    start_mask <= '0;

    test_name = "reset";
    repeat (RESET_CYCLES - 1) idle_tick();
    rst_drive = 1'b1;
    idle_tick();

    // every load here lands before ready and must be dropped
    test_name = "pre_ready";
    repeat (PRE_READY) begin
      r = next_rand();
      d = next_rand();
      tick(1'b1, tile_id_t'(r >> 8), addr_t'(r >> 12), d, r[0], tile_mask_t'(r >> 24));
    end

    test_name = "load_all";
    for (int k = 0; k < `SPMD_NUM_TILES; k++) begin
      for (int a = 0; a < `SPMD_DMEM_WORDS; a++) begin
        d = next_rand();
        tick(1'b1, tile_id_t'(k), addr_t'(a), d, 1'b0, '0);
      end
    end

    test_name = "start_all";  // all tiles finish together
    tick(1'b0, '0, '0, '0, 1'b1, '1);
    repeat (DRAIN) idle_tick();

    test_name = "random";
    repeat (RAND_CYCLES) begin
      r = next_rand();
      d = next_rand();
      tick(r[0], tile_id_t'(r >> 8), addr_t'(r >> 12), d, r[20:18] == 3'd0,
           tile_mask_t'(r >> 24));
    end
    repeat (DRAIN) idle_tick();

    test_name = "lone_start";
    t_lone = edge_n + 2;  // edge that samples the start
    tick(1'b0, '0, '0, '0, 1'b1, tile_mask_t'(1) << (`SPMD_NUM_TILES - 1));
    waited = 0;
    while (!stat_v) begin
      if (waited == DRAIN) begin
        abort_run("no print-stat record arrived after a lone tile start");
      end else begin
        idle_tick();
        waited++;
      end
    end
    check_cycle("lone start latency",
                cycle_t'(t_lone + `SPMD_DMEM_WORDS + 3 - rel_edge - READY_LAT), stat_cycle);
    repeat (DRAIN) idle_tick();

    if (records_seen == starts_m && pend_m == '0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run($sformatf("%0d print-stat records seen for %0d tile starts",
                          records_seen, starts_m));
    end
  end

endmodule

//--- src/spmd_top.sv
// spmd harness top: tag programmer, host loader and the tile array
`timescale 1ns/1ns
`include "spmd_config.svh"

module spmd_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  spmd_pkg::key_t       tag_seed_i,
  input  logic                 load_v_i,
  input  spmd_pkg::tile_id_t   load_tile_i,
  input  spmd_pkg::addr_t      load_addr_i,
  input  spmd_pkg::data_t      load_data_i,
  input  logic                 start_v_i,
  input  spmd_pkg::tile_mask_t start_mask_i,
  output logic                 ready_o,
  output logic                 drop_o,
  output logic                 print_stat_v_o,
  output spmd_pkg::tile_id_t   stat_tile_o,
  output spmd_pkg::data_t      stat_result_o,
  output spmd_pkg::cycle_t     stat_cycle_o
);

  import spmd_pkg::*;

  logic key_v;
  tile_id_t key_tile;
  key_t key_data;
  logic core_rst_n;
  tile_mask_t wr_v;
  addr_t wr_addr;
  data_t wr_data;
  tile_mask_t go;
  tile_mask_t busy;
  tile_mask_t done;
  data_t [`SPMD_NUM_TILES-1:0] results;

  tag_programmer u_tag_programmer (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.tag_seed_i(tag_seed_i)
    ,.key_v_o(key_v)
    ,.key_tile_o(key_tile)
    ,.key_data_o(key_data)
    ,.core_rst_n_o(core_rst_n)
  );

  spmd_loader u_loader (
    .clk_i(clk_i)
    ,.core_rst_n_i(core_rst_n)
    ,.load_v_i(load_v_i)
    ,.load_tile_i(load_tile_i)
    ,.load_addr_i(load_addr_i)
    ,.load_data_i(load_data_i)
    ,.start_v_i(start_v_i)
    ,.start_mask_i(start_mask_i)
    ,.busy_i(busy)
    ,.done_i(done)
    ,.results_i(results)
    ,.wr_v_o(wr_v)
    ,.wr_addr_o(wr_addr)
    ,.wr_data_o(wr_data)
    ,.go_o(go)
    ,.drop_o(drop_o)
    ,.ready_o(ready_o)
    ,.print_stat_v_o(print_stat_v_o)
    ,.stat_tile_o(stat_tile_o)
    ,.stat_result_o(stat_result_o)
    ,.stat_cycle_o(stat_cycle_o)
  );

  for (genvar i = 0; i < `SPMD_NUM_TILES; i++) begin : g_tile
    logic key_hit;  // key strobe decode
    assign key_hit = key_v & (key_tile == tile_id_t'(i));

    spmd_tile #(
      .TILE_ID(i)
    ) u_tile (
      .clk_i(clk_i)
      ,.core_rst_n_i(core_rst_n)
      ,.key_v_i(key_hit)
      ,.key_data_i(key_data)
      ,.wr_v_i(wr_v[i])
      ,.wr_addr_i(wr_addr)
      ,.wr_data_i(wr_data)
      ,.go_i(go[i])
      ,.busy_o(busy[i])
      ,.done_o(done[i])
      ,.result_o(results[i])
    );
  end

endmodule

//--- src/spmd_loader.sv
// host-side loader: routes loads and starts, flags drops, reports finished tiles
`timescale 1ns/1ns
`include "spmd_config.svh"

module spmd_loader (
  input  logic                                  clk_i,
  input  logic                                  core_rst_n_i,
  input  logic                                  load_v_i,
  input  spmd_pkg::tile_id_t                    load_tile_i,
  input  spmd_pkg::addr_t                       load_addr_i,
  input  spmd_pkg::data_t                       load_data_i,
  input  logic                                  start_v_i,
  input  spmd_pkg::tile_mask_t                  start_mask_i,
  input  spmd_pkg::tile_mask_t                  busy_i,
  input  spmd_pkg::tile_mask_t                  done_i,
  input  spmd_pkg::data_t [`SPMD_NUM_TILES-1:0] results_i,
  output spmd_pkg::tile_mask_t                  wr_v_o,
  output spmd_pkg::addr_t                       wr_addr_o,
  output spmd_pkg::data_t                       wr_data_o,
  output spmd_pkg::tile_mask_t                  go_o,
  output logic                                  drop_o,
  output logic                                  ready_o,
  output logic                                  print_stat_v_o,
  output spmd_pkg::tile_id_t                    stat_tile_o,
  output spmd_pkg::data_t                       stat_result_o,
  output spmd_pkg::cycle_t                      stat_cycle_o
);

  import spmd_pkg::*;

  tile_mask_t busy_eff;  // running, or go already on its way
  tile_mask_t load_sel;
  logic load_ok;
  logic load_drop;
  logic start_drop;
  tile_mask_t avail;
  tile_mask_t pick;
  tile_id_t pick_id;
  logic pick_v;
  tile_mask_t pend_r;
  data_t [`SPMD_NUM_TILES-1:0] slot_r;
  cycle_t cycle_r;
  cycle_t cycle_nxt;

  assign ready_o = core_rst_n_i;

  assign busy_eff   = busy_i | go_o;
  assign load_sel   = tile_mask_t'(1) << load_tile_i;
  assign load_ok    = load_v_i & ready_o & ~|(load_sel & busy_eff);
  assign load_drop  = load_v_i & ~load_ok;
  assign start_drop = start_v_i & (~ready_o | (|(start_mask_i & busy_eff)));

  always_ff @(posedge clk_i) begin
    if (!core_rst_n_i) begin
      wr_v_o <= '0;
      go_o   <= '0;
    end else begin
      wr_v_o <= load_ok ? load_sel : '0;
      go_o   <= start_v_i ? (start_mask_i & ~busy_eff) : '0;  // idle targets still go
    end
  end

  // drop stays live in core reset so early host inputs are flagged
  always_ff @(posedge clk_i) begin
    drop_o <= load_drop | start_drop;
    if (load_ok) begin
      wr_addr_o <= load_addr_i;
      wr_data_o <= load_data_i;
    end
  end

  // lowest finished tile first
  assign avail = pend_r | done_i;

  always_comb begin
    pick_v  = 1'b0;
    pick_id = '0;
    for (int i = `SPMD_NUM_TILES - 1; i >= 0; i--) begin
      if (avail[i]) begin
        pick_v  = 1'b1;
        pick_id = tile_id_t'(i);
      end
    end
  end

  assign pick      = pick_v ? (tile_mask_t'(1) << pick_id) : '0;
  assign cycle_nxt = cycle_r + 1'b1;

  always_ff @(posedge clk_i) begin
    if (!core_rst_n_i) begin
      pend_r         <= '0;
      print_stat_v_o <= 1'b0;
      cycle_r        <= '0;
    end else begin
      pend_r         <= avail & ~pick;
      print_stat_v_o <= pick_v;
      cycle_r        <= cycle_nxt;  // edges since core reset release
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `SPMD_NUM_TILES; i++) begin
      if (done_i[i]) slot_r[i] <= results_i[i];
    end
    if (pick_v) begin
      stat_tile_o   <= pick_id;
      stat_result_o <= done_i[pick_id] ? results_i[pick_id] : slot_r[pick_id];
      stat_cycle_o  <= cycle_nxt;
    end
  end

  // a tile finishes again only after its previous record went out
  a_pend_no_overrun: assert property (@(posedge clk_i) disable iff (!core_rst_n_i)
    !(|(done_i & pend_r)))
    else $error("done pulse on pending tiles %b", done_i & pend_r);

endmodule

//--- src/spmd_tile.sv
// one spmd tile: key register, local data memory and the sum-xor-key kernel
`timescale 1ns/1ns
`include "spmd_config.svh"

module spmd_tile #(
  parameter int unsigned TILE_ID = 0
) (
  input  logic            clk_i,
  input  logic            core_rst_n_i,
  input  logic            key_v_i,
  input  spmd_pkg::key_t  key_data_i,
  input  logic            wr_v_i,
  input  spmd_pkg::addr_t wr_addr_i,
  input  spmd_pkg::data_t wr_data_i,
  input  logic            go_i,
  output logic            busy_o,
  output logic            done_o,
  output spmd_pkg::data_t result_o
);

  import spmd_pkg::*;

  // one extra bit so the walk can count past the last word
  localparam int unsigned CNT_W = $bits(addr_t) + 1;

  key_t  key_r;
  data_t mem [`SPMD_DMEM_WORDS];
  data_t sum_r;
  data_t rd_word;
  logic [CNT_W-1:0] cnt_r;
  logic walk_end;

  assign walk_end = (cnt_r == CNT_W'(`SPMD_DMEM_WORDS));
  assign rd_word  = mem[cnt_r[CNT_W-2:0]];

  // written during core reset by the tag programmer
  always_ff @(posedge clk_i) begin
    if (key_v_i) key_r <= key_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (wr_v_i) mem[wr_addr_i] <= wr_data_i;
  end

  // kernel control
  always_ff @(posedge clk_i) begin
    if (!core_rst_n_i) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      cnt_r  <= '0;
    end else begin
      done_o <= 1'b0;
      if (go_i) begin
        busy_o <= 1'b1;
        cnt_r  <= '0;
      end else if (busy_o) begin
        if (walk_end) begin
          busy_o <= 1'b0;
          done_o <= 1'b1;  // one cycle pulse
        end else begin
          cnt_r <= cnt_r + 1'b1;
        end
      end
    end
  end

  // one word per cycle, wrapping sum
  always_ff @(posedge clk_i) begin
    if (go_i) begin
      sum_r <= '0;
    end else if (busy_o && !walk_end) begin
      sum_r <= sum_r + rd_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (busy_o && walk_end) result_o <= sum_r ^ key_r;  // held until next run
  end

  // the loader must filter writes and starts against busy
  a_no_touch_busy: assert property (@(posedge clk_i) disable iff (!core_rst_n_i)
    busy_o |-> !wr_v_i && !go_i)
    else $error("tile %0d written or started while busy", TILE_ID);

endmodule

//--- src/tag_programmer.sv
// writes each tile's key after reset, then releases core reset through a delay chain
`timescale 1ns/1ns
`include "spmd_config.svh"

module tag_programmer (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  spmd_pkg::key_t     tag_seed_i,
  output logic               key_v_o,
  output spmd_pkg::tile_id_t key_tile_o,
  output spmd_pkg::key_t     key_data_o,
  output logic               core_rst_n_o
);

  import spmd_pkg::*;

  key_t seed_r;
  logic started_r;  // seed taken
  logic done_r;
  logic [`SPMD_RESET_DEPTH-1:0] rst_chain_r;  // active high reset in flight

  // seed rotated left by one byte per tile
  function automatic key_t rotl_key(key_t v, tile_id_t k);
    int unsigned amt;
    amt = (8 * k) % $bits(key_t);
    return (v << amt) | (v >> ($bits(key_t) - amt));
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_n_i && !started_r) seed_r <= tag_seed_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      started_r  <= 1'b0;
      done_r     <= 1'b0;
      key_v_o    <= 1'b0;
      key_tile_o <= '0;
    end else if (!started_r) begin
      started_r  <= 1'b1;
      key_v_o    <= 1'b1;  // tile 0 next cycle
      key_tile_o <= '0;
    end else if (key_v_o) begin
      if (key_tile_o == tile_id_t'(`SPMD_NUM_TILES - 1)) begin
        key_v_o <= 1'b0;
        done_r  <= 1'b1;
      end else begin
        key_tile_o <= key_tile_o + 1'b1;
      end
    end
  end

  assign key_data_o = rotl_key(seed_r, key_tile_o);

  // ~done shifted through the chain
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) rst_chain_r <= '1;
    else rst_chain_r <= {rst_chain_r[`SPMD_RESET_DEPTH-2:0], ~done_r};
  end

  assign core_rst_n_o = ~rst_chain_r[`SPMD_RESET_DEPTH-1];

  // once released the cores stay out of reset
  a_core_rst_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) |-> !$fell(core_rst_n_o))
    else $error("core reset reasserted without a global reset");

endmodule

//--- src/spmd_pkg.sv
// shared types of the spmd harness; modules import it inside their bodies
`include "spmd_config.svh"

package spmd_pkg;

  localparam int unsigned ADDR_WIDTH =
    (`SPMD_DMEM_WORDS > 1) ? $clog2(`SPMD_DMEM_WORDS) : 1;

  localparam int unsigned TILE_ID_WIDTH =
    (`SPMD_NUM_TILES > 1) ? $clog2(`SPMD_NUM_TILES) : 1;

  // memory word or kernel result
  typedef logic [`SPMD_DATA_WIDTH-1:0] data_t;

  // word index inside one tile memory
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  typedef logic [TILE_ID_WIDTH-1:0] tile_id_t;

  // per-tile key, same width as a data word
  typedef logic [`SPMD_DATA_WIDTH-1:0] key_t;

  typedef logic [`SPMD_NUM_TILES-1:0] tile_mask_t;  // one bit per tile

  typedef logic [`SPMD_CYCLE_WIDTH-1:0] cycle_t;

endpackage

//--- src/spmd_config.svh
// build-time sizes of the spmd harness; include wherever a size macro is needed
`ifndef SPMD_CONFIG_SVH
`define SPMD_CONFIG_SVH

// tile array
`define SPMD_NUM_TILES 4

// words in each tile's local data memory
`define SPMD_DMEM_WORDS 16

// cycles between tag programming done and core reset release
`define SPMD_RESET_DEPTH 3

// memory word, kernel result and key width
`define SPMD_DATA_WIDTH 32

// global cycle counter width
`define SPMD_CYCLE_WIDTH 32

`endif
